// ==== common/psum_pkg.sv ====
package psum_pkg;

	// one partial sum, signed
	typedef logic signed [15:0] psum_t;

	// four partial sums, word 0 in the low bits
	typedef logic [63:0] psum_row_t;

	// low address bits pick the bank
	localparam int BANKS = 4;

	typedef enum logic [1:0] {
		acc_st_idle,
		acc_st_read,
		acc_st_write,
		acc_st_ack
	} acc_state_t;

	typedef enum logic [2:0] {
		drn_st_idle,
		drn_st_read,
		drn_st_capture,
		drn_st_clear,
		drn_st_ack
	} drn_state_t;

endpackage

// ==== list.f ====
common/psum_pkg.sv
psum_glb/dual_bram.sv
psum_glb/psum_glb.sv
logic/psum_accumulator.sv
logic/psum_drain.sv
logic/psum_buffer_top.sv
verif/psum_buffer_sva.sv
verif/psum_buffer_tb.sv

// ==== logic/psum_accumulator.sv ====
`timescale 1ns/1ps

module psum_accumulator #(
	parameter int MEM_DEPTH = 64,
	localparam int ADDR_WIDTH = $clog2(MEM_DEPTH)
) (
	input  logic                    clk,
	input  logic                    arst_n,

	// accumulate channel
	input  logic                    acc_req,
	input  logic [ADDR_WIDTH - 1:0] acc_addr,
	input  psum_pkg::psum_t         acc_data,
	input  logic                    acc_first,
	output logic                    acc_ack,

	// buffer port B
	output logic                    we_b,
	output logic                    re_b,
	output logic [ADDR_WIDTH - 1:0] addr_b,
	output psum_pkg::psum_t         wdata_b,
	input  psum_pkg::psum_t         rdata_b
);

	localparam int PSUM_W = $bits(psum_pkg::psum_t);
	localparam psum_pkg::psum_t PSUM_MAX = {1'b0, {(PSUM_W - 1){1'b1}}};
	localparam psum_pkg::psum_t PSUM_MIN = {1'b1, {(PSUM_W - 1){1'b0}}};

	psum_pkg::acc_state_t state;

	logic signed [PSUM_W:0] sum_wide;
	psum_pkg::psum_t        sum_sat;

	// one extra bit catches the overflow
	assign sum_wide = rdata_b + acc_data;

	always_comb begin
		if (sum_wide[PSUM_W] != sum_wide[PSUM_W - 1])
			sum_sat = sum_wide[PSUM_W] ? PSUM_MIN : PSUM_MAX;
		else
			sum_sat = sum_wide[PSUM_W - 1:0];
	end

	// requester holds address and data while req is high
	assign addr_b = acc_addr;
	assign re_b = (state == psum_pkg::acc_st_read);
	assign we_b = (state == psum_pkg::acc_st_write);
	assign wdata_b = acc_first ? acc_data : sum_sat;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= psum_pkg::acc_st_idle;
			acc_ack <= 1'b0;
		end else begin
			case (state)
				psum_pkg::acc_st_idle: begin
					if (acc_req)
						state <= psum_pkg::acc_st_read;
				end
				psum_pkg::acc_st_read: begin
					state <= psum_pkg::acc_st_write;
				end
				psum_pkg::acc_st_write: begin
					state <= psum_pkg::acc_st_ack;
				end
				psum_pkg::acc_st_ack: begin
					// held until req drops
					if (acc_ack && !acc_req) begin
						acc_ack <= 1'b0;
						state <= psum_pkg::acc_st_idle;
					end else begin
						acc_ack <= 1'b1;
					end
				end
				default: begin
					state <= psum_pkg::acc_st_idle;
					acc_ack <= 1'b0;
				end
			endcase
		end
	end

endmodule

// ==== logic/psum_buffer_top.sv ====
`timescale 1ns/1ps

module psum_buffer_top #(
	parameter int MEM_DEPTH = 64,
	localparam int ADDR_WIDTH = $clog2(MEM_DEPTH),
	localparam int ROW_WIDTH = $clog2(MEM_DEPTH / psum_pkg::BANKS)
) (
	input  logic                    clk,
	input  logic                    arst_n,

	// accumulate channel
	input  logic                    acc_req,
	input  logic [ADDR_WIDTH - 1:0] acc_addr,
	input  psum_pkg::psum_t         acc_data,
	input  logic                    acc_first,
	output logic                    acc_ack,

	// drain channel
	input  logic                    drn_req,
	input  logic [ROW_WIDTH - 1:0]  drn_row,
	output logic                    drn_ack,
	output psum_pkg::psum_row_t     drn_data
);

	// port A, drain side
	logic                    we_a;
	logic                    re_a;
	logic [ADDR_WIDTH - 1:0] addr_a;
	psum_pkg::psum_t         wdata_a;
	psum_pkg::psum_row_t     rdata_a;

	// port B, accumulator side
	logic                    we_b;
	logic                    re_b;
	logic [ADDR_WIDTH - 1:0] addr_b;
	psum_pkg::psum_t         wdata_b;
	psum_pkg::psum_t         rdata_b;

	psum_accumulator #(
		.MEM_DEPTH(MEM_DEPTH)
	) psum_accumulator_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.acc_req  (acc_req),
		.acc_addr (acc_addr),
		.acc_data (acc_data),
		.acc_first(acc_first),
		.acc_ack  (acc_ack),
		.we_b     (we_b),
		.re_b     (re_b),
		.addr_b   (addr_b),
		.wdata_b  (wdata_b),
		.rdata_b  (rdata_b)
	);

	psum_drain #(
		.MEM_DEPTH(MEM_DEPTH)
	) psum_drain_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.drn_req (drn_req),
		.drn_row (drn_row),
		.drn_ack (drn_ack),
		.drn_data(drn_data),
		.we_a    (we_a),
		.re_a    (re_a),
		.addr_a  (addr_a),
		.wdata_a (wdata_a),
		.rdata_a (rdata_a)
	);

	psum_glb #(
		.MEM_DEPTH(MEM_DEPTH)
	) psum_glb_i (
		.clk    (clk),
		.arst_n (arst_n),
		.we_a   (we_a),
		.re_a   (re_a),
		.addr_a (addr_a),
		.wdata_a(wdata_a),
		.rdata_a(rdata_a),
		.we_b   (we_b),
		.re_b   (re_b),
		.addr_b (addr_b),
		.wdata_b(wdata_b),
		.rdata_b(rdata_b)
	);

endmodule

// ==== logic/psum_drain.sv ====
`timescale 1ns/1ps

module psum_drain #(
	parameter int MEM_DEPTH = 64,
	localparam int ADDR_WIDTH = $clog2(MEM_DEPTH),
	localparam int ROW_WIDTH = $clog2(MEM_DEPTH / psum_pkg::BANKS)
) (
	input  logic                    clk,
	input  logic                    arst_n,

	// drain channel
	input  logic                    drn_req,
	input  logic [ROW_WIDTH - 1:0]  drn_row,
	output logic                    drn_ack,
	output psum_pkg::psum_row_t     drn_data,

	// buffer port A
	output logic                    we_a,
	output logic                    re_a,
	output logic [ADDR_WIDTH - 1:0] addr_a,
	output psum_pkg::psum_t         wdata_a,
	input  psum_pkg::psum_row_t     rdata_a
);

	localparam int BANK_BITS = $clog2(psum_pkg::BANKS);
	localparam logic [BANK_BITS - 1:0] LAST_BANK = BANK_BITS'(psum_pkg::BANKS - 1);

	psum_pkg::drn_state_t state;

	logic [BANK_BITS - 1:0] clr_cnt;
	psum_pkg::psum_row_t    row_q;

	// counter sits at zero outside the clear phase, so the read hits bank 0
	assign addr_a = {drn_row, clr_cnt};
	assign re_a = (state == psum_pkg::drn_st_read);
	assign we_a = (state == psum_pkg::drn_st_clear);
	assign wdata_a = '0;

	assign drn_data = row_q;

	always_ff @(posedge clk) begin
		if (state == psum_pkg::drn_st_capture)
			row_q <= rdata_a;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= psum_pkg::drn_st_idle;
			clr_cnt <= '0;
			drn_ack <= 1'b0;
		end else begin
			case (state)
				psum_pkg::drn_st_idle: begin
					if (drn_req)
						state <= psum_pkg::drn_st_read;
				end
				psum_pkg::drn_st_read: begin
					state <= psum_pkg::drn_st_capture;
				end
				psum_pkg::drn_st_capture: begin
					state <= psum_pkg::drn_st_clear;
				end
				psum_pkg::drn_st_clear: begin
					// one bank per cycle, wraps back to zero
					clr_cnt <= clr_cnt + 1'b1;
					if (clr_cnt == LAST_BANK)
						state <= psum_pkg::drn_st_ack;
				end
				psum_pkg::drn_st_ack: begin
					if (drn_ack && !drn_req) begin
						drn_ack <= 1'b0;
						state <= psum_pkg::drn_st_idle;
					end else begin
						drn_ack <= 1'b1;
					end
				end
				default: begin
					state <= psum_pkg::drn_st_idle;
					clr_cnt <= '0;
					drn_ack <= 1'b0;
				end
			endcase
		end
	end

endmodule

// ==== psum_glb/dual_bram.sv ====
`timescale 1ns/1ps

module dual_bram #(
	parameter int MEM_DEPTH = 16,
	localparam int ADDR_WIDTH = $clog2(MEM_DEPTH)
) (
	input  logic                    clk,
	input  logic                    arst_n,

	// port A
	input  logic                    we_a,
	input  logic                    re_a,
	input  logic [ADDR_WIDTH - 1:0] addr_a,
	input  psum_pkg::psum_t         wdata_a,
	output psum_pkg::psum_t         rdata_a,

	// port B
	input  logic                    we_b,
	input  logic                    re_b,
	input  logic [ADDR_WIDTH - 1:0] addr_b,
	input  psum_pkg::psum_t         wdata_b,
	output psum_pkg::psum_t         rdata_b
);

	psum_pkg::psum_t mem [MEM_DEPTH];

	always_ff @(posedge clk) begin
		if (we_a)
			mem[addr_a] <= wdata_a;
		if (we_b)
			mem[addr_b] <= wdata_b;
	end

	// registered reads, old data on a same-cycle write
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rdata_a <= '0;
			rdata_b <= '0;
		end else begin
			if (re_a)
				rdata_a <= mem[addr_a];
			if (re_b)
				rdata_b <= mem[addr_b];
		end
	end

endmodule

// ==== psum_glb/psum_glb.sv ====
`timescale 1ns/1ps

module psum_glb #(
	parameter int MEM_DEPTH = 64,
	localparam int ADDR_WIDTH = $clog2(MEM_DEPTH)
) (
	input  logic                    clk,
	input  logic                    arst_n,

	// port A, word write and full row read
	input  logic                    we_a,
	input  logic                    re_a,
	input  logic [ADDR_WIDTH - 1:0] addr_a,
	input  psum_pkg::psum_t         wdata_a,
	output psum_pkg::psum_row_t     rdata_a,

	// port B, word write and word read
	input  logic                    we_b,
	input  logic                    re_b,
	input  logic [ADDR_WIDTH - 1:0] addr_b,
	input  psum_pkg::psum_t         wdata_b,
	output psum_pkg::psum_t         rdata_b
);

	localparam int BANK_BITS = $clog2(psum_pkg::BANKS);
	localparam int BANK_DEPTH = MEM_DEPTH / psum_pkg::BANKS;
	localparam int PSUM_W = $bits(psum_pkg::psum_t);

	logic [BANK_BITS - 1:0] bank_a;
	logic [BANK_BITS - 1:0] bank_b;
	logic [BANK_BITS - 1:0] bank_b_r;

	psum_pkg::psum_t rdata_a_bank [psum_pkg::BANKS];
	psum_pkg::psum_t rdata_b_bank [psum_pkg::BANKS];

	assign bank_a = addr_a[BANK_BITS - 1:0];
	assign bank_b = addr_b[BANK_BITS - 1:0];

	// port B bank select follows the read by one cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			bank_b_r <= '0;
		else
			bank_b_r <= bank_b;
	end

	assign rdata_b = rdata_b_bank[bank_b_r];

	// bank 0 lands in the low word
	always_comb begin
		rdata_a = '0;
		for (int i = 0; i < psum_pkg::BANKS; i++) begin
			rdata_a[i * PSUM_W +: PSUM_W] = rdata_a_bank[i];
		end
	end

	for (genvar b = 0; b < psum_pkg::BANKS; b++) begin : g_bank
		logic sel_a;
		logic sel_b;

		assign sel_a = (bank_a == BANK_BITS'(b));
		assign sel_b = (bank_b == BANK_BITS'(b));

		dual_bram #(
			.MEM_DEPTH(BANK_DEPTH)
		) dual_bram_i (
			.clk    (clk),
			.arst_n (arst_n),

			// all banks read together on port A
			.we_a   (we_a && sel_a),
			.re_a   (re_a),
			.addr_a (addr_a[ADDR_WIDTH - 1:BANK_BITS]),
			.wdata_a(wdata_a),
			.rdata_a(rdata_a_bank[b]),

			.we_b   (we_b && sel_b),
			.re_b   (re_b && sel_b),
			.addr_b (addr_b[ADDR_WIDTH - 1:BANK_BITS]),
			.wdata_b(wdata_b),
			.rdata_b(rdata_b_bank[b])
		);
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the partial-sum buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module psum_buffer_tb \
	-f list.f > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vpsum_buffer_tb > sim.log 2>&1
cat sim.log
grep -qx "Verification passed" sim.log && echo "simulation ok" || {
	echo "simulation did not pass, see sim.log"
	exit 1
}

// ==== verif/psum_buffer_sva.sv ====
`timescale 1ns/1ps

module psum_buffer_sva #(
	parameter int MEM_DEPTH = 64,
	localparam int ADDR_WIDTH = $clog2(MEM_DEPTH)
) (
	input logic                    clk,
	input logic                    arst_n,
	input logic                    acc_req,
	input logic                    acc_ack,
	input logic                    drn_req,
	input logic                    drn_ack,
	input logic                    we_a,
	input logic                    we_b,
	input logic [ADDR_WIDTH - 1:0] addr_a,
	input logic [ADDR_WIDTH - 1:0] addr_b
);

	// ack is set on the edge that still sees req high
	acc_ack_rise: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(acc_ack) |-> $past(acc_req))
		else $error("acc_ack rose without acc_req");

	drn_ack_rise: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(drn_ack) |-> $past(drn_req))
		else $error("drn_ack rose without drn_req");

	acc_ack_hold: assert property (@(posedge clk) disable iff (!arst_n)
		acc_ack && acc_req |=> acc_ack)
		else $error("acc_ack dropped while acc_req was high");

	drn_ack_hold: assert property (@(posedge clk) disable iff (!arst_n)
		drn_ack && drn_req |=> drn_ack)
		else $error("drn_ack dropped while drn_req was high");

	// no arbitration, so the two ports must never collide on a word
	port_conflict: assert property (@(posedge clk) disable iff (!arst_n)
		!(we_a && we_b && addr_a == addr_b))
		else $error("port A and port B wrote the same word");

endmodule

bind psum_buffer_top psum_buffer_sva #(
	.MEM_DEPTH(MEM_DEPTH)
) psum_buffer_sva_i (
	.clk    (clk),
	.arst_n (arst_n),
	.acc_req(acc_req),
	.acc_ack(acc_ack),
	.drn_req(drn_req),
	.drn_ack(drn_ack),
	.we_a   (we_a),
	.we_b   (we_b),
	.addr_a (addr_a),
	.addr_b (addr_b)
);

// ==== verif/psum_buffer_tb.sv ====
`timescale 1ns/1ps

module psum_buffer_tb;

	localparam int MEM_DEPTH = 64;
	localparam int ACC_LAT = 3;
	localparam int DRN_LAT = 7;
	localparam int WAIT_LIMIT = 40;

	logic                clk;
	logic                arst_n;
	logic                acc_req;
	logic [5:0]          acc_addr;
	psum_pkg::psum_t     acc_data;
	logic                acc_first;
	logic                acc_ack;
	logic                drn_req;
	logic [3:0]          drn_row;
	logic                drn_ack;
	psum_pkg::psum_row_t drn_data;

	// reference contents of the buffer
	logic signed [15:0] model [MEM_DEPTH];

	logic [31:0] lcg_state;
	int          errors;
	int          checks;
	int          tests;
	int          test_start_errors;
	logic        timed_out;

	psum_buffer_top #(
		.MEM_DEPTH(MEM_DEPTH)
	) psum_buffer_top_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.acc_req  (acc_req),
		.acc_addr (acc_addr),
		.acc_data (acc_data),
		.acc_first(acc_first),
		.acc_ack  (acc_ack),
		.drn_req  (drn_req),
		.drn_row  (drn_row),
		.drn_ack  (drn_ack),
		.drn_data (drn_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [15:0] rand_word();
		logic [31:0] r;
		r = next_rand();
		return r[31:16];
	endfunction

	function automatic logic [3:0] rand_row();
		logic [31:0] r;
		r = next_rand();
		return r[29:26];
	endfunction

	function automatic logic signed [15:0] saturate_add(logic signed [15:0] a,
			logic signed [15:0] b);
		int s;
		s = int'(a) + int'(b);
		if (s > 32767)
			return 16'sh7fff;
		if (s < -32768)
			return 16'sh8000;
		return s[15:0];
	endfunction

	function automatic psum_pkg::psum_row_t model_row(logic [3:0] row);
		psum_pkg::psum_row_t r;
		for (int w = 0; w < 4; w++)
			r[w * 16 +: 16] = model[int'(row) * 4 + w];
		return r;
	endfunction

	// all driving and sampling happens 1 ns after the rising edge
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		checks++;
		assert (got === exp)
		else begin
			$display("error: %s got %0h expected %0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic wait_ack(input logic on_drain, input logic level, output int cycles);
		logic ack;
		cycles = 0;
		ack = on_drain ? drn_ack : acc_ack;
		while (ack !== level && cycles < WAIT_LIMIT) begin
			step();
			cycles++;
			ack = on_drain ? drn_ack : acc_ack;
		end
		if (ack !== level) begin
			$display("timeout: %s did not go to %0d within %0d cycles",
				on_drain ? "drn_ack" : "acc_ack", level, WAIT_LIMIT);
			errors++;
			timed_out = 1'b1;
		end
	endtask

	task automatic run_accumulate(input logic [5:0] addr, input logic [15:0] data,
			input logic first, input int hold);
		int              cycles;
		psum_pkg::psum_t expected;
		if (timed_out)
			return;
		expected = first ? data : saturate_add(model[addr], data);
		acc_addr = addr;
		acc_data = data;
		acc_first = first;
		acc_req = 1'b1;
		wait_ack(1'b0, 1'b1, cycles);
		if (timed_out)
			return;
		// first edge only samples the request
		check_value("acc_ack rise latency", cycles - 1, ACC_LAT);
		for (int i = 0; i < hold; i++) begin
			step();
			check_value("acc_ack", acc_ack, 1);
		end
		model[addr] = expected;
		acc_req = 1'b0;
		wait_ack(1'b0, 1'b0, cycles);
		check_value("acc_ack fall latency", cycles, 1);
	endtask

	task automatic run_drain(input logic [3:0] row, input logic check_data, input int hold);
		int                  cycles;
		psum_pkg::psum_row_t expected;
		if (timed_out)
			return;
		expected = model_row(row);
		drn_row = row;
		drn_req = 1'b1;
		wait_ack(1'b1, 1'b1, cycles);
		if (timed_out)
			return;
		check_value("drn_ack rise latency", cycles - 1, DRN_LAT);
		if (check_data)
			check_value("drn_data", drn_data, expected);
		for (int i = 0; i < hold; i++) begin
			step();
			check_value("drn_ack", drn_ack, 1);
			if (check_data)
				check_value("drn_data", drn_data, expected);
		end
		drn_req = 1'b0;
		wait_ack(1'b1, 1'b0, cycles);
		check_value("drn_ack fall latency", cycles, 1);
		for (int w = 0; w < 4; w++)
			model[int'(row) * 4 + w] = '0;
	endtask

	task automatic finish_test(input string name);
		$display("test %s done, %0d errors", name, errors - test_start_errors);
		tests++;
		test_start_errors = errors;
	endtask

	initial begin
		logic [3:0]  row;
		logic [3:0]  other;
		logic [1:0]  word;
		logic [15:0] val;
		lcg_state = 32'd69;
		errors = 0;
		checks = 0;
		tests = 0;
		test_start_errors = 0;
		timed_out = 1'b0;
		arst_n = 1'b0;
		acc_req = 1'b0;
		acc_addr = '0;
		acc_data = '0;
		acc_first = 1'b0;
		drn_req = 1'b0;
		drn_row = '0;
		repeat (3) @(posedge clk);
		#1;
		arst_n = 1'b1;

		// memories come up unknown, so the first pass only clears them
		check_value("acc_ack", acc_ack, 0);
		check_value("drn_ack", drn_ack, 0);
		for (int r = 0; r < 16; r++)
			run_drain(4'(r), 1'b0, 0);
		run_accumulate({rand_row(), 2'd0}, rand_word(), 1'b1, 0);
		run_drain(4'd0, 1'b1, 0);
		finish_test("reset_and_latency");

		row = rand_row();
		for (int w = 0; w < 4; w++)
			run_accumulate({row, 2'(w)}, rand_word(), 1'b1, 0);
		run_drain(row, 1'b1, 0);
		row = row ^ 4'h8;
		word = rand_word() >> 14;
		val = rand_word();
		run_accumulate({row, word}, val, 1'b1, 0);
		run_drain(row, 1'b1, 0);
		check_value("drn_data word", drn_data, {48'h0, val} << (16 * int'(word)));
		finish_test("first_store");

		run_accumulate(6'd16, 16'h7000, 1'b1, 0);
		run_accumulate(6'd16, 16'h2000, 1'b0, 0);
		run_accumulate(6'd17, 16'h9000, 1'b1, 0);
		run_accumulate(6'd17, 16'he000, 1'b0, 0);
		for (int i = 0; i < 40; i++) begin
			row = rand_row();
			val = rand_word();
			run_accumulate({2'b01, row[1:0], val[1:0]}, rand_word(), rand_word() < 16'h2000, 0);
		end
		for (int r = 4; r < 8; r++)
			run_drain(4'(r), 1'b1, 0);
		finish_test("saturating_sums");

		for (int w = 0; w < 4; w++)
			run_accumulate({4'd8, 2'(w)}, rand_word(), 1'b1, 0);
		run_drain(4'd8, 1'b1, 0);
		run_drain(4'd8, 1'b1, 0);
		check_value("drn_data", drn_data, 0);
		run_accumulate({4'd8, 2'd3}, rand_word(), 1'b0, 0);
		run_drain(4'd8, 1'b1, 0);
		finish_test("drain_clears");

		for (int i = 0; i < 8; i++) begin
			row = rand_row();
			other = row ^ (rand_row() | 4'h1);
			word = rand_word() >> 14;
			val = rand_word();
			fork
				run_accumulate({other, word}, val, rand_word() < 16'h4000, 0);
				run_drain(row, 1'b1, 0);
			join
		end
		for (int r = 0; r < 16; r++)
			run_drain(4'(r), 1'b1, 0);
		finish_test("concurrent_channels");

		for (int w = 0; w < 4; w++)
			run_accumulate({4'd10, 2'(w)}, rand_word(), 1'b1, 0);
		run_accumulate({4'd11, 2'd1}, rand_word(), 1'b0, 4);
		run_drain(4'd10, 1'b1, 5);
		run_drain(4'd11, 1'b1, 3);
		finish_test("held_request");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0 && !timed_out)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule
